// ==== Makefile ====
TOP = conv_store_ctrl_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	  -f conv_store_ctrl.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "test passed"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
	  -f conv_store_ctrl.f --top-module conv_store_ctrl

clean:
	rm -rf obj_dir

// ==== conv_store_ctrl.f ====
+incdir+logic
+incdir+testbench
logic/conv_store_pkg.sv
logic/store_burst_if.sv
logic/fifo_read_if.sv
logic/store_cmd_gen.sv
logic/fifo_read_sequencer.sv
logic/ddr_word_packer.sv
logic/conv_store_ctrl.sv
testbench/conv_store_ctrl_tb.sv

// ==== logic/conv_store_ctrl.sv ====
`timescale 1ns/1ps
`include "conv_store_macros.svh"

module conv_store_ctrl (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        start,
  input  conv_store_pkg::store_mode_t mode,
  input  conv_store_pkg::adr_t        layer_base_adr,
  input  logic [3:0]                  of_in_2pow,
  input  logic [3:0]                  ox_in_2pow,
  input  logic [15:0]                 cur_oy_start,
  input  logic [15:0]                 cur_ox_start,
  input  logic [15:0]                 cur_of_start,
  input  logic [15:0]                 cur_poy,
  input  logic [15:0]                 cur_pof,
  input  logic                        ddr_cmd_ready,
  output conv_store_pkg::adr_t        store_ddr_base_adr,
  output conv_store_pkg::len_t        store_ddr_length,
  output logic                        store_cmd_valid,
  input  logic                        ddr_wt_data_ready,
  output conv_store_pkg::word_t       ddr_data,
  output logic                        ddr_data_valid,
  output logic [`FIFO_NUM-1:0]        fifo_rds,
  input  conv_store_pkg::word_t       fifo_data,
  output logic                        conv_store_fin
);
  import conv_store_pkg::*;

  store_mode_t mode_q;
  tile_cfg_t   cfg_q;

  // layer and tile setup held for the whole tile
  always_ff @(posedge clk) begin
    if (start) begin
      mode_q <= mode;
      cfg_q  <= '{layer_base_adr: layer_base_adr,
                  of_in_2pow:     of_in_2pow,
                  ox_in_2pow:     ox_in_2pow,
                  oy_start:       cur_oy_start,
                  ox_start:       cur_ox_start,
                  of_start:       cur_of_start,
                  poy:            cur_poy,
                  pof:            cur_pof};
    end
  end

  store_burst_if burst_if ();
  fifo_read_if   rd_if ();

  store_cmd_gen store_cmd_gen_i (
    .clk                (clk),
    .reset              (reset),
    .start              (start),
    .cfg                (cfg_q),
    .ddr_cmd_ready      (ddr_cmd_ready),
    .store_ddr_base_adr (store_ddr_base_adr),
    .store_ddr_length   (store_ddr_length),
    .store_cmd_valid    (store_cmd_valid),
    .burst              (burst_if.gen)
  );

  fifo_read_sequencer fifo_read_sequencer_i (
    .clk      (clk),
    .reset    (reset),
    .mode     (mode_q),
    .cur_pof  (cfg_q.pof),
    .cur_poy  (cfg_q.poy),
    .fifo_rds (fifo_rds),
    .burst    (burst_if.seq),
    .rd       (rd_if.seq)
  );

  ddr_word_packer ddr_word_packer_i (
    .clk               (clk),
    .reset             (reset),
    .fifo_data         (fifo_data),
    .ddr_wt_data_ready (ddr_wt_data_ready),
    .ddr_data          (ddr_data),
    .ddr_data_valid    (ddr_data_valid),
    .conv_store_fin    (conv_store_fin),
    .rd                (rd_if.pack)
  );

endmodule

// ==== logic/conv_store_macros.svh ====
`ifndef CONV_STORE_MACROS_SVH
`define CONV_STORE_MACROS_SVH

// row FIFO grid of the systolic array
`define SA_ROWS 4
`define SA_COLS 3
`define FIFO_NUM (`SA_ROWS * `SA_COLS)

// pixel and word widths
`define PIX_W 8
`define PIX_IN_WORD_LOG 5
`define HALF_W (`PIX_W << `PIX_IN_WORD_LOG)
`define WORD_W (`HALF_W * 2)

// ddr store command limit
`define CMD_WORDS 32

// two channels share one ddr word
`define CH_PER_WORD_LOG 1

// channels held by one row FIFO
`define BLOCK_CH_M0 16
`define BLOCK_CH_M1 32

`endif

// ==== logic/conv_store_pkg.sv ====
`include "conv_store_macros.svh"

package conv_store_pkg;

  // mode 0 packs two half reads, mode 1 takes one full read
  typedef enum logic {
    MODE_HALF = 1'b0,
    MODE_FULL = 1'b1
  } store_mode_t;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [15:0] len_t;
  typedef logic [31:0] adr_t;

  // walk counters and FIFO select
  typedef logic [15:0] cnt_t;
  typedef logic [$clog2(`FIFO_NUM)-1:0] fifo_idx_t;

  // layer and tile description, latched on start
  typedef struct packed {
    adr_t        layer_base_adr;
    logic [3:0]  of_in_2pow;
    logic [3:0]  ox_in_2pow;
    logic [15:0] oy_start;
    logic [15:0] ox_start;
    logic [15:0] of_start;
    logic [15:0] poy;
    logic [15:0] pof;
  } tile_cfg_t;

endpackage

// ==== logic/ddr_word_packer.sv ====
`timescale 1ns/1ps
`include "conv_store_macros.svh"

module ddr_word_packer (
  input  logic                  clk,
  input  logic                  reset,
  input  conv_store_pkg::word_t fifo_data,
  input  logic                  ddr_wt_data_ready,
  output conv_store_pkg::word_t ddr_data,
  output logic                  ddr_data_valid,
  output logic                  conv_store_fin,
  fifo_read_if.pack             rd
);
  import conv_store_pkg::*;

  // read flags aligned with fifo_data
  logic rd_d;
  logic first_d;
  logic last_word_d;
  logic last_tile_d;

  // set between the two halves of a mode 0 word
  logic pair_open;
  logic [`HALF_W-1:0] low_half;

  logic  fresh_valid;
  word_t fresh_word;

  // word parked under back-pressure
  logic  held_valid;
  logic  held_last;
  word_t held_word;

  logic word_last;

  always_ff @(posedge clk) begin
    first_d     <= rd.rd_first_half;
    last_word_d <= rd.rd_last_of_word;
    last_tile_d <= rd.rd_last_of_tile;
  end

  // the word completes in the cycle its last read returns
  assign fresh_valid = rd_d && last_word_d;
  assign fresh_word  = pair_open ? {fifo_data[`HALF_W-1:0], low_half} : fifo_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_d       <= 1'b0;
      pair_open  <= 1'b0;
      held_valid <= 1'b0;
    end else begin
      rd_d <= rd.rd_valid;
      if (rd_d && first_d) begin
        pair_open <= 1'b1;
      end else if (fresh_valid) begin
        pair_open <= 1'b0;
      end
      if (fresh_valid && !ddr_wt_data_ready) begin
        held_valid <= 1'b1;
      end else if (held_valid && ddr_wt_data_ready) begin
        held_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_d && first_d) begin
      low_half <= fifo_data[`HALF_W-1:0];
    end
    if (fresh_valid) begin
      held_word <= fresh_word;
      held_last <= last_tile_d;
    end
  end

  ////////////////////////////////////////
  // output side
  ////////////////////////////////////////

  assign ddr_data_valid = held_valid || fresh_valid;
  assign ddr_data       = held_valid ? held_word : fresh_word;
  assign word_last      = held_valid ? held_last : last_tile_d;

  assign rd.word_pending  = ddr_data_valid;
  assign rd.word_accepted = ddr_data_valid && ddr_wt_data_ready;

  // last word of the tile leaves the packer
  assign conv_store_fin = rd.word_accepted && word_last;

endmodule

// ==== logic/fifo_read_if.sv ====
`timescale 1ns/1ps

interface fifo_read_if;

  // read events, one per issued fifo read
  logic rd_valid;
  logic rd_first_half;
  logic rd_last_of_word;
  logic rd_last_of_tile;

  // output word state in the packer
  logic word_pending;
  logic word_accepted;

  modport seq (
    output rd_valid,
    output rd_first_half,
    output rd_last_of_word,
    output rd_last_of_tile,
    input  word_pending,
    input  word_accepted
  );

  modport pack (
    input  rd_valid,
    input  rd_first_half,
    input  rd_last_of_word,
    input  rd_last_of_tile,
    output word_pending,
    output word_accepted
  );

endinterface

// ==== logic/fifo_read_sequencer.sv ====
`timescale 1ns/1ps
`include "conv_store_macros.svh"

module fifo_read_sequencer (
  input  logic                        clk,
  input  logic                        reset,
  input  conv_store_pkg::store_mode_t mode,
  input  logic [15:0]                 cur_pof,
  input  logic [15:0]                 cur_poy,
  output logic [`FIFO_NUM-1:0]        fifo_rds,
  store_burst_if.seq                  burst,
  fifo_read_if.seq                    rd
);
  import conv_store_pkg::*;

  localparam int BLK_LOG_M0 = $clog2(`BLOCK_CH_M0);
  localparam int BLK_LOG_M1 = $clog2(`BLOCK_CH_M1);

  // walk position: channel in block (0-based), block, row (1-based)
  cnt_t ch_in_blk;
  cnt_t blk;
  cnt_t oy;

  cnt_t blk_ch;
  cnt_t step;
  cnt_t pos;
  logic [2:0] blk_log;

  // per command word counts
  len_t words_rd;
  len_t words_acc;
  logic busy;

  logic row_end;
  logic blk_end;
  logic last_of_word;
  logic issue;
  fifo_idx_t fifo_idx;

  ////////////////////////////////////////
  // mode dependent geometry
  ////////////////////////////////////////

  assign blk_ch  = (mode == MODE_HALF) ? cnt_t'(`BLOCK_CH_M0) : cnt_t'(`BLOCK_CH_M1);
  assign blk_log = (mode == MODE_HALF) ? 3'(BLK_LOG_M0) : 3'(BLK_LOG_M1);
  // one channel per read in mode 0, two in mode 1
  assign step    = (mode == MODE_HALF) ? 16'd1 : 16'd2;

  // channel offset in the row, always even at a word start
  assign pos = (blk << blk_log) + ch_in_blk;

  assign row_end      = (pos + step >= cur_pof);
  assign blk_end      = (ch_in_blk + step == blk_ch);
  assign last_of_word = (mode == MODE_FULL) || pos[0];

  ////////////////////////////////////////
  // read issue
  ////////////////////////////////////////

  // no read while an unaccepted word sits at the output
  assign issue = busy && (words_rd < burst.cmd_length)
              && (!rd.word_pending || rd.word_accepted);

  assign fifo_idx = fifo_idx_t'((oy - 16'd1) * `SA_ROWS + blk);

  always_comb begin
    fifo_rds = '0;
    if (issue) begin
      fifo_rds[fifo_idx] = 1'b1;
    end
  end

  assign rd.rd_valid        = issue;
  assign rd.rd_first_half   = (mode == MODE_HALF) && !pos[0];
  assign rd.rd_last_of_word = last_of_word;
  assign rd.rd_last_of_tile = row_end && (oy == cur_poy);

  ////////////////////////////////////////
  // tile walk
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || !burst.tile_active) begin
      ch_in_blk <= '0;
      blk       <= '0;
      oy        <= 16'd1;
    end else if (issue) begin
      if (row_end) begin
        ch_in_blk <= '0;
        blk       <= '0;
        oy        <= (oy == cur_poy) ? 16'd1 : oy + 16'd1;
      end else if (blk_end) begin
        // next FIFO of the same row
        ch_in_blk <= '0;
        blk       <= blk + 16'd1;
      end else begin
        ch_in_blk <= ch_in_blk + step;
      end
    end
  end

  ////////////////////////////////////////
  // command progress
  ////////////////////////////////////////

  assign burst.burst_done = busy && rd.word_accepted
                         && (words_acc + 16'd1 == burst.cmd_length);
  assign burst.burst_busy = busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      words_rd  <= '0;
      words_acc <= '0;
    end else if (burst.cmd_valid) begin
      busy      <= 1'b1;
      words_rd  <= '0;
      words_acc <= '0;
    end else begin
      if (burst.burst_done) begin
        busy <= 1'b0;
      end
      if (issue && last_of_word) begin
        words_rd <= words_rd + 16'd1;
      end
      if (busy && rd.word_accepted) begin
        words_acc <= words_acc + 16'd1;
      end
    end
  end

endmodule

// ==== logic/store_burst_if.sv ====
`timescale 1ns/1ps

interface store_burst_if;
  import conv_store_pkg::*;

  // command side, from the generator
  logic cmd_valid;
  len_t cmd_length;
  logic tile_active;

  // progress side, from the read sequencer
  logic burst_busy;
  logic burst_done;

  modport gen (
    output cmd_valid,
    output cmd_length,
    output tile_active,
    input  burst_busy,
    input  burst_done
  );

  modport seq (
    input  cmd_valid,
    input  cmd_length,
    input  tile_active,
    output burst_busy,
    output burst_done
  );

endinterface

// ==== logic/store_cmd_gen.sv ====
`timescale 1ns/1ps
`include "conv_store_macros.svh"

module store_cmd_gen (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  conv_store_pkg::tile_cfg_t cfg,
  input  logic                      ddr_cmd_ready,
  output conv_store_pkg::adr_t      store_ddr_base_adr,
  output conv_store_pkg::len_t      store_ddr_length,
  output logic                      store_cmd_valid,
  store_burst_if.gen                burst
);
  import conv_store_pkg::*;

  logic tile_active;
  logic cmd_lock;
  logic last_issued;
  logic cmd_go;
  logic row_end;

  // row and first channel of the next command, both 1-based
  cnt_t oy_cnt;
  cnt_t ch_cnt;

  len_t rem_words;
  len_t next_len;

  logic [5:0] row_sh;
  logic [4:0] col_sh;
  adr_t row_off;
  adr_t col_off;
  adr_t ch_off;

  ////////////////////////////////////////
  // command length
  ////////////////////////////////////////

  // words left in this row from ch_cnt on
  assign rem_words = len_t'((cfg.pof - ch_cnt + 16'd1) >> `CH_PER_WORD_LOG);
  assign row_end   = (rem_words <= len_t'(`CMD_WORDS));
  assign next_len  = row_end ? rem_words : len_t'(`CMD_WORDS);

  ////////////////////////////////////////
  // base address terms
  ////////////////////////////////////////

  // one output row spans of*ox channels, two per word, 32 pixels per word
  assign row_sh = 6'(cfg.of_in_2pow) + 6'(cfg.ox_in_2pow)
                - 6'(`CH_PER_WORD_LOG + `PIX_IN_WORD_LOG);
  assign col_sh = 5'(cfg.of_in_2pow) - 5'(`CH_PER_WORD_LOG);

  assign row_off = (adr_t'(cfg.oy_start) + adr_t'(oy_cnt) - 32'd2) << row_sh;
  assign col_off = ((adr_t'(cfg.ox_start) - 32'd1) << col_sh) >> `PIX_IN_WORD_LOG;
  assign ch_off  = (adr_t'(cfg.of_start) + adr_t'(ch_cnt) - 32'd2) >> `CH_PER_WORD_LOG;

  ////////////////////////////////////////
  // issue control
  ////////////////////////////////////////

  // the lock covers the gap until burst_busy is seen
  assign cmd_go = tile_active && !last_issued && !burst.burst_busy
               && !cmd_lock && ddr_cmd_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      tile_active     <= 1'b0;
      cmd_lock        <= 1'b0;
      last_issued     <= 1'b0;
      store_cmd_valid <= 1'b0;
      oy_cnt          <= 16'd1;
      ch_cnt          <= 16'd1;
    end else begin
      store_cmd_valid <= cmd_go;

      if (store_cmd_valid) begin
        cmd_lock <= 1'b0;
      end else if (cmd_go) begin
        cmd_lock <= 1'b1;
      end

      if (start) begin
        tile_active <= 1'b1;
        last_issued <= 1'b0;
        oy_cnt      <= 16'd1;
        ch_cnt      <= 16'd1;
      end else begin
        // tile stays active until its last word is out
        if (burst.burst_done && last_issued) begin
          tile_active <= 1'b0;
        end
        if (cmd_go) begin
          if (row_end) begin
            ch_cnt <= 16'd1;
            if (oy_cnt == cfg.poy) begin
              oy_cnt      <= 16'd1;
              last_issued <= 1'b1;
            end else begin
              oy_cnt <= oy_cnt + 16'd1;
            end
          end else begin
            ch_cnt <= ch_cnt + cnt_t'(next_len << `CH_PER_WORD_LOG);
          end
        end
      end
    end
  end

  // command payload, held until the next command
  always_ff @(posedge clk) begin
    if (cmd_go) begin
      store_ddr_length   <= next_len;
      store_ddr_base_adr <= cfg.layer_base_adr + row_off + col_off + ch_off;
    end
  end

  assign burst.cmd_valid   = store_cmd_valid;
  assign burst.cmd_length  = store_ddr_length;
  assign burst.tile_active = tile_active;

endmodule

// ==== testbench/conv_store_model.svh ====
`ifndef CONV_STORE_MODEL_SVH
`define CONV_STORE_MODEL_SVH

// reference model of one tile, word and command numbers are 0-based

function automatic int words_per_row(input tile_cfg_t c);
  return int'(c.pof) / 2;
endfunction

function automatic int cmds_per_row(input tile_cfg_t c);
  return (words_per_row(c) + `CMD_WORDS - 1) / `CMD_WORDS;
endfunction

function automatic int cmd_count(input tile_cfg_t c);
  return cmds_per_row(c) * int'(c.poy);
endfunction

function automatic int word_count(input tile_cfg_t c);
  return words_per_row(c) * int'(c.poy);
endfunction

// two reads per word in mode 0
function automatic int read_total(input store_mode_t m, input tile_cfg_t c);
  return (m == MODE_HALF) ? 2 * word_count(c) : word_count(c);
endfunction

// last command of a row takes the remainder
function automatic len_t cmd_len(input tile_cfg_t c, input int k);
  int left;
  left = words_per_row(c) - (k % cmds_per_row(c)) * `CMD_WORDS;
  return len_t'((left < `CMD_WORDS) ? left : `CMD_WORDS);
endfunction

function automatic adr_t cmd_adr(input tile_cfg_t c, input int k);
  int   oy;
  int   first_ch;
  adr_t row_part;
  adr_t col_part;
  adr_t ch_part;
  oy       = k / cmds_per_row(c) + 1;
  first_ch = (k % cmds_per_row(c)) * `CMD_WORDS * 2 + 1;
  row_part = (adr_t'(c.oy_start) + adr_t'(oy) - 2)
           << (int'(c.of_in_2pow) + int'(c.ox_in_2pow) - 6);
  col_part = ((adr_t'(c.ox_start) - 1) << (int'(c.of_in_2pow) - 1)) >> 5;
  ch_part  = (adr_t'(c.of_start) + adr_t'(first_ch) - 2) >> 1;
  return c.layer_base_adr + row_part + col_part + ch_part;
endfunction

// row FIFO contents, from FIFO index and that FIFO's read count
function automatic word_t fifo_value(input int idx, input int cnt);
  word_t v;
  for (int i = 0; i < `WORD_W / 32; i++) begin
    v[i*32 +: 32] = {8'(idx), 8'(cnt), 8'(i), 8'hc3};
  end
  return v;
endfunction

function automatic word_t word_value(input store_mode_t m, input tile_cfg_t c, input int w);
  int    oy;
  int    ch;
  int    fifo;
  word_t lo;
  word_t hi;
  oy = w / words_per_row(c) + 1;
  ch = (w % words_per_row(c)) * 2;
  if (m == MODE_FULL) begin
    fifo = (oy - 1) * `SA_ROWS + ch / `BLOCK_CH_M1;
    return fifo_value(fifo, (ch % `BLOCK_CH_M1) / 2);
  end
  // one channel per read, first read in the low half
  fifo = (oy - 1) * `SA_ROWS + ch / `BLOCK_CH_M0;
  lo   = fifo_value(fifo, ch % `BLOCK_CH_M0);
  hi   = fifo_value(fifo, ch % `BLOCK_CH_M0 + 1);
  return {hi[`HALF_W-1:0], lo[`HALF_W-1:0]};
endfunction

`endif

// ==== testbench/conv_store_ctrl_tb.sv ====
`timescale 1ns/1ps
`include "conv_store_macros.svh"

module conv_store_ctrl_tb;
  import conv_store_pkg::*;

  logic                 clk;
  logic                 reset;
  logic                 start;
  store_mode_t          mode;
  adr_t                 layer_base_adr;
  logic [3:0]           of_in_2pow;
  logic [3:0]           ox_in_2pow;
  logic [15:0]          cur_oy_start;
  logic [15:0]          cur_ox_start;
  logic [15:0]          cur_of_start;
  logic [15:0]          cur_poy;
  logic [15:0]          cur_pof;
  logic                 ddr_cmd_ready;
  adr_t                 store_ddr_base_adr;
  len_t                 store_ddr_length;
  logic                 store_cmd_valid;
  logic                 ddr_wt_data_ready;
  word_t                ddr_data;
  logic                 ddr_data_valid;
  logic [`FIFO_NUM-1:0] fifo_rds;
  word_t                fifo_data;
  logic                 conv_store_fin;

  integer      seed = 68;
  tile_cfg_t   tile_a;
  tile_cfg_t   tile_b;
  tile_cfg_t   cur_cfg;
  store_mode_t cur_mode;
  int          watchdog_cycles = 0;
  int          tiles_done = 0;
  int          fifo_reads [`FIFO_NUM];

  // checker state
  int    cmd_idx;
  int    word_idx;
  int    rd_count;
  int    words_left;
  logic  cmd_ready_d;
  logic  stall_d;
  word_t data_d;
  word_t exp_word;
  len_t  exp_len;
  adr_t  exp_adr;

  `include "conv_store_model.svh"

  conv_store_ctrl conv_store_ctrl_i (
    .clk                (clk),
    .reset              (reset),
    .start              (start),
    .mode               (mode),
    .layer_base_adr     (layer_base_adr),
    .of_in_2pow         (of_in_2pow),
    .ox_in_2pow         (ox_in_2pow),
    .cur_oy_start       (cur_oy_start),
    .cur_ox_start       (cur_ox_start),
    .cur_of_start       (cur_of_start),
    .cur_poy            (cur_poy),
    .cur_pof            (cur_pof),
    .ddr_cmd_ready      (ddr_cmd_ready),
    .store_ddr_base_adr (store_ddr_base_adr),
    .store_ddr_length   (store_ddr_length),
    .store_cmd_valid    (store_cmd_valid),
    .ddr_wt_data_ready  (ddr_wt_data_ready),
    .ddr_data           (ddr_data),
    .ddr_data_valid     (ddr_data_valid),
    .fifo_rds           (fifo_rds),
    .fifo_data          (fifo_data),
    .conv_store_fin     (conv_store_fin)
  );

  always #50 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("ERROR: %s", reason);
    $display("test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input word_t got, input word_t exp);
    $display("MISMATCH %s got %0h expected %0h", name, got, exp);
    $display("test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic start_tile(input store_mode_t m, input tile_cfg_t c);
    @(posedge clk);
    mode           <= m;
    layer_base_adr <= c.layer_base_adr;
    of_in_2pow     <= c.of_in_2pow;
    ox_in_2pow     <= c.ox_in_2pow;
    cur_oy_start   <= c.oy_start;
    cur_ox_start   <= c.ox_start;
    cur_of_start   <= c.of_start;
    cur_poy        <= c.poy;
    cur_pof        <= c.pof;
    cur_mode       <= m;
    cur_cfg        <= c;
    start          <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  ////////////////////////////////////////
  // row FIFO model and ddr back-pressure
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (start) begin
      for (int i = 0; i < `FIFO_NUM; i++) begin
        fifo_reads[i] = 0;
      end
    end else begin
      for (int i = 0; i < `FIFO_NUM; i++) begin
        if (fifo_rds[i]) begin
          fifo_data     <= fifo_value(i, fifo_reads[i]);
          fifo_reads[i] = fifo_reads[i] + 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    ddr_cmd_ready     <= ($random(seed) & 3) != 0;
    ddr_wt_data_ready <= ($random(seed) & 1) != 0;
  end

  ////////////////////////////////////////
  // response checks
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (reset || start) begin
      cmd_idx    = 0;
      word_idx   = 0;
      rd_count   = 0;
      words_left = 0;
      stall_d    = 1'b0;
    end else begin
      if (fifo_rds != '0) begin
        assert ($onehot(fifo_rds)) else abort_run("more than one row FIFO read in a cycle");
        rd_count++;
      end
      if (store_cmd_valid) begin
        assert (cmd_ready_d) else abort_run("command issued without ddr_cmd_ready before it");
        assert (words_left == 0) else abort_run("command issued while one is in progress");
        assert (cmd_idx < cmd_count(cur_cfg)) else abort_run("more commands than the tile needs");
        exp_len = cmd_len(cur_cfg, cmd_idx);
        exp_adr = cmd_adr(cur_cfg, cmd_idx);
        assert (store_ddr_length == exp_len) else
          report_mismatch("store_ddr_length", word_t'(store_ddr_length), word_t'(exp_len));
        assert (store_ddr_base_adr == exp_adr) else
          report_mismatch("store_ddr_base_adr", word_t'(store_ddr_base_adr), word_t'(exp_adr));
        words_left = int'(store_ddr_length);
        cmd_idx++;
      end
      // stalled word stays put
      if (stall_d) begin
        assert (ddr_data_valid) else abort_run("ddr_data_valid dropped before acceptance");
        assert (ddr_data == data_d) else report_mismatch("ddr_data", ddr_data, data_d);
      end
      if (ddr_data_valid && ddr_wt_data_ready) begin
        assert (words_left > 0) else abort_run("word accepted outside a command");
        assert (word_idx < word_count(cur_cfg)) else abort_run("more words than the tile holds");
        exp_word = word_value(cur_mode, cur_cfg, word_idx);
        assert (ddr_data == exp_word) else report_mismatch("ddr_data", ddr_data, exp_word);
        assert (conv_store_fin == (word_idx == word_count(cur_cfg) - 1)) else
          report_mismatch("conv_store_fin", word_t'(conv_store_fin),
                          word_t'(word_idx == word_count(cur_cfg) - 1));
        if (conv_store_fin) begin
          assert (cmd_idx == cmd_count(cur_cfg)) else
            report_mismatch("command count", word_t'(cmd_idx), word_t'(cmd_count(cur_cfg)));
          assert (rd_count == read_total(cur_mode, cur_cfg)) else
            report_mismatch("fifo_rds pulse count", word_t'(rd_count),
                            word_t'(read_total(cur_mode, cur_cfg)));
          tiles_done <= tiles_done + 1;
        end
        words_left--;
        word_idx++;
      end else begin
        assert (!conv_store_fin) else abort_run("conv_store_fin without an accepted word");
      end
      stall_d = ddr_data_valid && !ddr_wt_data_ready;
      data_d  = ddr_data;
    end
    cmd_ready_d = ddr_cmd_ready;
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    clk               = 1'b0;
    reset             = 1'b1;
    start             = 1'b0;
    mode              = MODE_HALF;
    layer_base_adr    = '0;
    of_in_2pow        = '0;
    ox_in_2pow        = '0;
    cur_oy_start      = '0;
    cur_ox_start      = '0;
    cur_of_start      = '0;
    cur_poy           = '0;
    cur_pof           = '0;
    ddr_cmd_ready     = 1'b0;
    ddr_wt_data_ready = 1'b0;
    fifo_data         = '0;
    // base, of_in_2pow, ox_in_2pow, oy/ox/of start, poy, pof
    tile_a = '{32'h1000_0000, 4'd7, 4'd4, 16'd2, 16'd3, 16'd1, 16'd3, 16'd128};
    tile_b = '{32'h2000_0000, 4'd7, 4'd5, 16'd5, 16'd9, 16'd65, 16'd2, 16'd40};
    cur_cfg  = tile_a;
    cur_mode = MODE_FULL;
    watchdog_cycles = 40 * (word_count(tile_a) + word_count(tile_b)) + 400;

    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (fifo_rds == '0 && !store_cmd_valid && !ddr_data_valid && !conv_store_fin) else
      abort_run("control outputs not low after reset");

    // full width reads, two commands per row
    start_tile(MODE_FULL, tile_a);
    while (tiles_done < 1) @(posedge clk);
    repeat (5) @(posedge clk);

    // paired half reads on a second tile
    start_tile(MODE_HALF, tile_b);
    while (tiles_done < 2) @(posedge clk);

    // nothing more may come out once the tile is done
    repeat (50) @(posedge clk);
    @(negedge clk);
    assert (rd_count == read_total(cur_mode, cur_cfg)) else
      report_mismatch("fifo_rds pulse count", word_t'(rd_count),
                      word_t'(read_total(cur_mode, cur_cfg)));
    assert (cmd_idx == cmd_count(cur_cfg)) else
      report_mismatch("command count", word_t'(cmd_idx), word_t'(cmd_count(cur_cfg)));
    $display("test passed");
    $finish;
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    abort_run($sformatf("timeout, tiles not finished within %0d cycles", watchdog_cycles));
  end

endmodule
